// File: fragPkg.sv
// Fragment pipeline package
// Channel widths, color, depth and index types, the comparison,
// texture environment and blend factor encodings, and the channel math
// shared by the execute and result stages

`default_nettype none

package fragPkg;

    localparam int channelW     = 4;
    localparam int productW     = 8;
    localparam int indexW       = 14;
    localparam int channelCount = 4;

    // Full intensity, stands for 1.0
    localparam logic [channelW-1:0] channelMax = 4'hf;

    // RGBA4444, red in the top nibble, alpha in the bottom nibble
    typedef logic [15:0]       colorT;
    typedef logic [15:0]       depthT;
    typedef logic [indexW-1:0] indexT;

    typedef enum logic [2:0] {
        cmpNever, cmpLess, cmpEqual, cmpLequal,
        cmpGreater, cmpNotEqual, cmpGequal, cmpAlways
    } cmpFuncE;

    typedef enum logic [2:0] {
        texDisable, texReplace, texModulate, texDecal, texBlend, texAdd
    } texEnvE;

    typedef enum logic [3:0] {
        blendZero, blendOne, blendSrcColor, blendOneMinusSrcColor,
        blendDstColor, blendOneMinusDstColor, blendSrcAlpha, blendOneMinusSrcAlpha,
        blendDstAlpha, blendOneMinusDstAlpha, blendSrcAlphaSaturate
    } blendFactorE;

    function automatic logic [productW-1:0] mulChannel(
        input logic [channelW-1:0] a,
        input logic [channelW-1:0] b
    );
        return productW'(a) * productW'(b);
    endfunction

    // Sum of two products, rounded up and saturated to one channel
    function automatic logic [channelW-1:0] mixChannel(
        input logic [productW-1:0] a,
        input logic [productW-1:0] b
    );
        logic [productW:0] sum;
        sum = (productW+1)'(a) + (productW+1)'(b) + (productW+1)'(channelMax);
        return sum[productW] ? channelMax : sum[productW-1 -: channelW];
    endfunction

    // Shared by the depth test and the alpha test
    function automatic logic cmpPass(
        input cmpFuncE     func,
        input logic [15:0] value,
        input logic [15:0] refValue
    );
        case (func)
            cmpNever:    return 1'b0;
            cmpLess:     return value < refValue;
            cmpEqual:    return value == refValue;
            cmpLequal:   return value <= refValue;
            cmpGreater:  return value > refValue;
            cmpNotEqual: return value != refValue;
            cmpGequal:   return value >= refValue;
            default:     return 1'b1;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: fragStageIf.sv
// Stage-to-stage buses of the fragment pipeline
// fragStageIf carries a fragment with its destination values from decode to execute,
// shadeIf carries the shaded source color and depth result from execute to result

`timescale 1ns/1ps
`default_nettype none

interface fragStageIf;
    logic            valid;
    fragPkg::indexT  index;
    fragPkg::depthT  depth;
    fragPkg::colorT  triColor;
    fragPkg::colorT  texel;
    fragPkg::colorT  dstColor;
    fragPkg::depthT  dstDepth;

    modport source (
        output valid, index, depth, triColor, texel, dstColor, dstDepth
    );

    modport sink (
        input valid, index, depth, triColor, texel, dstColor, dstDepth
    );
endinterface

interface shadeIf;
    logic            valid;
    fragPkg::indexT  index;
    fragPkg::depthT  depth;
    fragPkg::colorT  srcColor;
    fragPkg::colorT  dstColor;
    // Raw depth compare, the enable is applied later
    logic            depthPass;

    modport source (
        output valid, index, depth, srcColor, dstColor, depthPass
    );

    modport sink (
        input valid, index, depth, srcColor, dstColor, depthPass
    );
endinterface

`default_nettype wire

// File: fragDecode.sv
// Fragment decode stage
// Captures incoming fragments, presents the framebuffer and depth read
// index, and joins the returned memory data with the fragment

`timescale 1ns/1ps
`default_nettype none

module fragDecode (
    input  wire                   clk,
    input  wire                   rstN,
    input  wire                   fragValid,
    input  wire  fragPkg::indexT  fragIndex,
    input  wire  fragPkg::depthT  fragDepth,
    input  wire  fragPkg::colorT  fragColor,
    input  wire  fragPkg::colorT  fragTexel,
    output fragPkg::indexT        colorReadIndex,
    output fragPkg::indexT        depthReadIndex,
    input  wire  fragPkg::colorT  colorIn,
    input  wire  fragPkg::depthT  depthIn,
    fragStageIf.source            down
);

    typedef struct packed {
        fragPkg::indexT index;
        fragPkg::depthT depth;
        fragPkg::colorT triColor;
        fragPkg::colorT texel;
    } fragT;

    logic       capValid;
    fragT       capFrag;
    logic [1:0] shiftValid;
    fragT [1:0] shiftFrag;

    // Valid chain
    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            capValid   <= 1'b0;
            shiftValid <= '0;
            down.valid <= 1'b0;
        end
        else
        begin
            capValid   <= fragValid;
            shiftValid <= {shiftValid[0], capValid};
            down.valid <= shiftValid[1];
        end
    end

    // Fragment fields wait out the memory read
    always_ff @(posedge clk)
    begin
        capFrag   <= '{index: fragIndex, depth: fragDepth, triColor: fragColor, texel: fragTexel};
        shiftFrag <= {shiftFrag[0], capFrag};

        down.index    <= shiftFrag[1].index;
        down.depth    <= shiftFrag[1].depth;
        down.triColor <= shiftFrag[1].triColor;
        down.texel    <= shiftFrag[1].texel;
        down.dstColor <= colorIn;
        down.dstDepth <= depthIn;
    end

    // Both memories see the index one edge after capture
    assign colorReadIndex = shiftFrag[0].index;
    assign depthReadIndex = shiftFrag[0].index;

    validKnown: assert property (@(posedge clk) disable iff (!rstN) !$isunknown(fragValid))
        else $error("fragValid is unknown");

endmodule

`default_nettype wire

// File: fragExecute.sv
// Fragment execute stage
// Texture environment multiply-add of texel, triangle color and
// environment color, and the depth comparison against the depth buffer

`timescale 1ns/1ps
`default_nettype none

module fragExecute (
    input  wire                   clk,
    input  wire                   rstN,
    input  wire  fragPkg::texEnvE texEnvMode,
    input  wire  fragPkg::colorT  texEnvColor,
    input  wire  fragPkg::cmpFuncE depthFunc,
    fragStageIf.sink              up,
    shadeIf.source                down
);

    logic [fragPkg::channelCount-1:0][fragPkg::channelW-1:0] p0, q0, p1, q1;
    logic [fragPkg::channelCount-1:0][fragPkg::productW-1:0] prodA, prodB;

    logic            validA;
    fragPkg::indexT  indexA;
    fragPkg::depthT  depthA;
    fragPkg::colorT  dstColorA;
    logic            depthPassA;

    //////////////////////////////////////////////////
    // Operand selection
    //////////////////////////////////////////////////
    // s texel, p triangle color, c environment color
    always_comb
    begin : operandSelect
        logic [fragPkg::channelW-1:0] s, p, c, as;
        as = up.texel[fragPkg::channelW-1:0];
        for (int ch = 0; ch < fragPkg::channelCount; ch++)
        begin
            s = up.texel[ch*fragPkg::channelW +: fragPkg::channelW];
            p = up.triColor[ch*fragPkg::channelW +: fragPkg::channelW];
            c = texEnvColor[ch*fragPkg::channelW +: fragPkg::channelW];

            // Default is p * 1 + 0 * 0
            p0[ch] = p;
            q0[ch] = fragPkg::channelMax;
            p1[ch] = '0;
            q1[ch] = '0;

            if (ch == 0)
            begin
                // Alpha channel
                case (texEnvMode)
                    fragPkg::texReplace:  p0[ch] = as;
                    fragPkg::texModulate,
                    fragPkg::texBlend,
                    fragPkg::texAdd:      q0[ch] = as;
                    default:              ;
                endcase
            end
            else
            begin
                case (texEnvMode)
                    fragPkg::texReplace:  p0[ch] = s;
                    fragPkg::texModulate: q0[ch] = s;
                    fragPkg::texDecal:
                    begin
                        q0[ch] = fragPkg::channelMax - as;
                        p1[ch] = s;
                        q1[ch] = as;
                    end
                    fragPkg::texBlend:
                    begin
                        q0[ch] = fragPkg::channelMax - s;
                        p1[ch] = c;
                        q1[ch] = s;
                    end
                    fragPkg::texAdd:
                    begin
                        p1[ch] = s;
                        q1[ch] = fragPkg::channelMax;
                    end
                    default:              ;
                endcase
            end
        end
    end

    //////////////////////////////////////////////////
    // Products and mix
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            validA     <= 1'b0;
            down.valid <= 1'b0;
        end
        else
        begin
            validA     <= up.valid;
            down.valid <= validA;
        end
    end

    always_ff @(posedge clk)
    begin
        for (int ch = 0; ch < fragPkg::channelCount; ch++)
        begin
            prodA[ch] <= fragPkg::mulChannel(p0[ch], q0[ch]);
            prodB[ch] <= fragPkg::mulChannel(p1[ch], q1[ch]);
            down.srcColor[ch*fragPkg::channelW +: fragPkg::channelW] <=
                fragPkg::mixChannel(prodA[ch], prodB[ch]);
        end
        // Early depth compare, only the result bit travels on
        depthPassA <= fragPkg::cmpPass(depthFunc, up.depth, up.dstDepth);
        indexA     <= up.index;
        depthA     <= up.depth;
        dstColorA  <= up.dstColor;

        down.depthPass <= depthPassA;
        down.index     <= indexA;
        down.depth     <= depthA;
        down.dstColor  <= dstColorA;
    end

    depthPassKnown: assert property (
        @(posedge clk) disable iff (!rstN) down.valid |-> !$isunknown(down.depthPass)
    ) else $error("depthPass unknown on a valid shade beat");

endmodule

`default_nettype wire

// File: fragResult.sv
// Fragment result stage
// Alpha test, blending of the shaded color with the framebuffer color,
// and the color and depth write-back with their write enables

`timescale 1ns/1ps
`default_nettype none

module fragResult (
    input  wire                        clk,
    input  wire                        rstN,
    input  wire  fragPkg::cmpFuncE     alphaFunc,
    input  wire  [fragPkg::channelW-1:0] alphaRef,
    input  wire  fragPkg::blendFactorE blendSrc,
    input  wire  fragPkg::blendFactorE blendDst,
    input  wire                        depthTestEnable,
    shadeIf.sink                       up,
    output fragPkg::indexT             colorWriteIndex,
    output fragPkg::colorT             colorOut,
    output logic                       colorWriteEnable,
    output fragPkg::indexT             depthWriteIndex,
    output fragPkg::depthT             depthOut,
    output logic                       depthWriteEnable
);

    logic [fragPkg::channelCount-1:0][fragPkg::productW-1:0] srcProd, dstProd;

    logic            validC, validD;
    logic            passC, passD;
    fragPkg::indexT  indexC, indexD;
    fragPkg::depthT  depthC, depthD;
    fragPkg::colorT  colorD;

    // Factor for one channel, ch 0 is alpha
    function automatic logic [fragPkg::channelW-1:0] blendFactor(
        input fragPkg::blendFactorE factor,
        input fragPkg::colorT       src,
        input fragPkg::colorT       dst,
        input int                   ch
    );
        logic [fragPkg::channelW-1:0] sc, dc, sa, da, sat;
        sc  = src[ch*fragPkg::channelW +: fragPkg::channelW];
        dc  = dst[ch*fragPkg::channelW +: fragPkg::channelW];
        sa  = src[fragPkg::channelW-1:0];
        da  = dst[fragPkg::channelW-1:0];
        sat = (sa < fragPkg::channelMax - da) ? sa : fragPkg::channelMax - da;
        case (factor)
            fragPkg::blendOne:              return fragPkg::channelMax;
            fragPkg::blendSrcColor:         return sc;
            fragPkg::blendOneMinusSrcColor: return fragPkg::channelMax - sc;
            fragPkg::blendDstColor:         return dc;
            fragPkg::blendOneMinusDstColor: return fragPkg::channelMax - dc;
            fragPkg::blendSrcAlpha:         return sa;
            fragPkg::blendOneMinusSrcAlpha: return fragPkg::channelMax - sa;
            fragPkg::blendDstAlpha:         return da;
            fragPkg::blendOneMinusDstAlpha: return fragPkg::channelMax - da;
            fragPkg::blendSrcAlphaSaturate: return (ch == 0) ? fragPkg::channelMax : sat;
            default:                        return '0;
        endcase
    endfunction

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            validC           <= 1'b0;
            validD           <= 1'b0;
            colorWriteEnable <= 1'b0;
            depthWriteEnable <= 1'b0;
        end
        else
        begin
            validC           <= up.valid;
            validD           <= validC;
            colorWriteEnable <= validD && passD;
            depthWriteEnable <= validD && passD && depthTestEnable;
        end
    end

    //////////////////////////////////////////////////
    // Alpha test and blend products
    //////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        for (int ch = 0; ch < fragPkg::channelCount; ch++)
        begin
            srcProd[ch] <= fragPkg::mulChannel(
                up.srcColor[ch*fragPkg::channelW +: fragPkg::channelW],
                blendFactor(blendSrc, up.srcColor, up.dstColor, ch));
            dstProd[ch] <= fragPkg::mulChannel(
                up.dstColor[ch*fragPkg::channelW +: fragPkg::channelW],
                blendFactor(blendDst, up.srcColor, up.dstColor, ch));
        end
        // A disabled depth test always passes
        passC  <= fragPkg::cmpPass(alphaFunc, 16'(up.srcColor[fragPkg::channelW-1:0]),
                                   16'(alphaRef))
                  && (up.depthPass || !depthTestEnable);
        indexC <= up.index;
        depthC <= up.depth;

        // Blended sums
        for (int ch = 0; ch < fragPkg::channelCount; ch++)
        begin
            colorD[ch*fragPkg::channelW +: fragPkg::channelW] <=
                fragPkg::mixChannel(srcProd[ch], dstProd[ch]);
        end
        passD  <= passC;
        indexD <= indexC;
        depthD <= depthC;

        //////////////////////////////////////////////////
        // Write-back
        //////////////////////////////////////////////////
        colorWriteIndex <= indexD;
        depthWriteIndex <= indexD;
        colorOut        <= colorD;
        depthOut        <= depthD;
    end

    // The depth compare of the same fragment sat on the shade bus three edges earlier
    depthImpliesColor: assert property (
        @(posedge clk) disable iff (!rstN)
        depthWriteEnable |-> colorWriteEnable && $past(up.depthPass, 3)
    ) else $error("Depth written without a color write or a passing depth compare");

endmodule

`default_nettype wire

// File: fragmentPipeline.sv
// Fragment shading pipeline top level
// Decode, execute and result stages joined by the stage buses,
// with the fragment stream, configuration and memory ports

`timescale 1ns/1ps
`default_nettype none

module fragmentPipeline (
    input  wire                          clk,
    input  wire                          rstN,
    // Fragment stream
    input  wire                          fragValid,
    input  wire  fragPkg::indexT         fragIndex,
    input  wire  fragPkg::depthT         fragDepth,
    input  wire  fragPkg::colorT         fragColor,
    input  wire  fragPkg::colorT         fragTexel,
    // Configuration
    input  wire  fragPkg::cmpFuncE       depthFunc,
    input  wire                          depthTestEnable,
    input  wire  fragPkg::cmpFuncE       alphaFunc,
    input  wire  [fragPkg::channelW-1:0] alphaRef,
    input  wire  fragPkg::texEnvE        texEnvMode,
    input  wire  fragPkg::colorT         texEnvColor,
    input  wire  fragPkg::blendFactorE   blendSrc,
    input  wire  fragPkg::blendFactorE   blendDst,
    // Memory reads
    output fragPkg::indexT               colorReadIndex,
    output fragPkg::indexT               depthReadIndex,
    input  wire  fragPkg::colorT         colorIn,
    input  wire  fragPkg::depthT         depthIn,
    // Memory writes
    output fragPkg::indexT               colorWriteIndex,
    output fragPkg::colorT               colorOut,
    output logic                         colorWriteEnable,
    output fragPkg::indexT               depthWriteIndex,
    output fragPkg::depthT               depthOut,
    output logic                         depthWriteEnable
);

    fragStageIf stageBus ();
    shadeIf     shadeBus ();

    fragDecode i_decode (
        .clk, .rstN, .fragValid, .fragIndex, .fragDepth, .fragColor, .fragTexel,
        .colorReadIndex, .depthReadIndex, .colorIn, .depthIn,
        .down (stageBus.source)
    );

    fragExecute i_execute (
        .clk, .rstN, .texEnvMode, .texEnvColor, .depthFunc,
        .up   (stageBus.sink),
        .down (shadeBus.source)
    );

    fragResult i_result (
        .clk, .rstN, .alphaFunc, .alphaRef, .blendSrc, .blendDst, .depthTestEnable,
        .up (shadeBus.sink),
        .colorWriteIndex, .colorOut, .colorWriteEnable,
        .depthWriteIndex, .depthOut, .depthWriteEnable
    );

endmodule

`default_nettype wire

// File: tbFragModel.svh
// Fragment pipeline reference model
// Texture environment, comparison and blend rules computed channel by
// channel with integer math, for the testbench checker

`ifndef tbFragModelSvh
`define tbFragModelSvh

// Channel ch as an integer, ch 0 is alpha
function automatic int channelOf(input fragPkg::colorT color, input int ch);
    return int'(color[ch*4 +: 4]);
endfunction

// Two products summed, rounded up by 15/16 and clipped at full intensity
function automatic int mixRef(input int prodA, input int prodB);
    int sum;
    sum = prodA + prodB + 15;
    if (sum >= 256)
        return 15;
    return sum / 16;
endfunction

function automatic fragPkg::colorT texEnvRef(
    input fragPkg::texEnvE mode,
    input fragPkg::colorT  triColor,
    input fragPkg::colorT  texel,
    input fragPkg::colorT  envColor
);
    fragPkg::colorT result;
    int p, s, c, as, value;
    as = channelOf(texel, 0);
    result = '0;
    for (int ch = 0; ch < 4; ch++)
    begin
        p = channelOf(triColor, ch);
        s = channelOf(texel, ch);
        c = channelOf(envColor, ch);
        if (ch == 0)
        begin
            case (mode)
                fragPkg::texReplace:  value = mixRef(s * 15, 0);
                fragPkg::texModulate,
                fragPkg::texBlend,
                fragPkg::texAdd:      value = mixRef(p * s, 0);
                default:              value = mixRef(p * 15, 0);
            endcase
        end
        else
        begin
            case (mode)
                fragPkg::texReplace:  value = mixRef(s * 15, 0);
                fragPkg::texModulate: value = mixRef(p * s, 0);
                fragPkg::texDecal:    value = mixRef(p * (15 - as), s * as);
                fragPkg::texBlend:    value = mixRef(p * (15 - s), c * s);
                fragPkg::texAdd:      value = mixRef(p * 15, s * 15);
                default:              value = mixRef(p * 15, 0);
            endcase
        end
        result[ch*4 +: 4] = 4'(value);
    end
    return result;
endfunction

function automatic bit cmpRef(
    input fragPkg::cmpFuncE func,
    input logic [15:0]      value,
    input logic [15:0]      refValue
);
    logic [2:0] code;
    int         v;
    int         r;
    code = func;
    v    = int'(value);
    r    = int'(refValue);
    // Bit 0 passes on less, bit 1 on equal, bit 2 on greater
    return (code[0] && v < r) || (code[1] && v == r) || (code[2] && v > r);
endfunction

function automatic int factorRef(
    input fragPkg::blendFactorE factor,
    input fragPkg::colorT       src,
    input fragPkg::colorT       dst,
    input int                   ch
);
    int sc, dc, sa, da;
    sc = channelOf(src, ch);
    dc = channelOf(dst, ch);
    sa = channelOf(src, 0);
    da = channelOf(dst, 0);
    case (factor)
        fragPkg::blendOne:              return 15;
        fragPkg::blendSrcColor:         return sc;
        fragPkg::blendOneMinusSrcColor: return 15 - sc;
        fragPkg::blendDstColor:         return dc;
        fragPkg::blendOneMinusDstColor: return 15 - dc;
        fragPkg::blendSrcAlpha:         return sa;
        fragPkg::blendOneMinusSrcAlpha: return 15 - sa;
        fragPkg::blendDstAlpha:         return da;
        fragPkg::blendOneMinusDstAlpha: return 15 - da;
        fragPkg::blendSrcAlphaSaturate: return (ch == 0) ? 15 : ((sa < 15 - da) ? sa : 15 - da);
        default:                        return 0;
    endcase
endfunction

function automatic fragPkg::colorT blendRef(
    input fragPkg::colorT       src,
    input fragPkg::colorT       dst,
    input fragPkg::blendFactorE srcFactor,
    input fragPkg::blendFactorE dstFactor
);
    fragPkg::colorT result;
    int value;
    result = '0;
    for (int ch = 0; ch < 4; ch++)
    begin
        value = mixRef(channelOf(src, ch) * factorRef(srcFactor, src, dst, ch),
                       channelOf(dst, ch) * factorRef(dstFactor, src, dst, ch));
        result[ch*4 +: 4] = 4'(value);
    end
    return result;
endfunction

`endif

// File: tbFragmentPipeline.sv
// Testbench for the fragment shading pipeline
// Random fragments in configuration groups, framebuffer and depth
// memory models, and a reference check of every write-back cycle

`timescale 1ns/1ps
`default_nettype none

module tbFragmentPipeline;

    localparam int memDepth      = 1 << fragPkg::indexW;
    localparam int fragsPerGroup = 12;
    localparam int groupCount    = 6 + 16 + 8 + 24;
    // Fragments plus pipeline drain per group, then reset and slack
    localparam int runCycles     = groupCount * (fragsPerGroup + 12) + 4 + 50;
    // Acceptance edge plus eight pipeline edges, counted from the driving negedge
    localparam int writeDelay    = 9;
    // Acceptance edge plus the edge that presents the read index
    localparam int readDelay     = 2;

    typedef struct {
        fragPkg::indexT index;
        fragPkg::depthT depth;
        fragPkg::colorT triColor;
        fragPkg::colorT texel;
        fragPkg::colorT dstColor;
        fragPkg::depthT dstDepth;
        int             due;
    } expectT;

    logic                         clk             = 1'b0;
    logic                         rstN            = 1'b0;
    logic                         fragValid       = 1'b0;
    fragPkg::indexT               fragIndex       = '0;
    fragPkg::depthT               fragDepth       = '0;
    fragPkg::colorT               fragColor       = '0;
    fragPkg::colorT               fragTexel       = '0;
    fragPkg::cmpFuncE             depthFunc       = fragPkg::cmpAlways;
    logic                         depthTestEnable = 1'b1;
    fragPkg::cmpFuncE             alphaFunc       = fragPkg::cmpAlways;
    logic [fragPkg::channelW-1:0] alphaRef        = '0;
    fragPkg::texEnvE              texEnvMode      = fragPkg::texDisable;
    fragPkg::colorT               texEnvColor     = '0;
    fragPkg::blendFactorE         blendSrc        = fragPkg::blendOne;
    fragPkg::blendFactorE         blendDst        = fragPkg::blendZero;
    fragPkg::colorT               colorIn         = '0;
    fragPkg::depthT               depthIn         = '0;

    fragPkg::indexT colorReadIndex;
    fragPkg::indexT depthReadIndex;
    fragPkg::indexT colorWriteIndex;
    fragPkg::colorT colorOut;
    logic           colorWriteEnable;
    fragPkg::indexT depthWriteIndex;
    fragPkg::depthT depthOut;
    logic           depthWriteEnable;

    fragPkg::colorT colorMem  [memDepth];
    fragPkg::depthT depthMem  [memDepth];
    // Preload copies, the reference for destination values
    fragPkg::colorT colorInit [memDepth];
    fragPkg::depthT depthInit [memDepth];

    expectT pending [$];
    integer seed       = 32'h977c;
    int     cycleCount = 0;
    int     fragCount  = 0;
    string  testName   = "reset";

    `include "tbFragModel.svh"

    fragmentPipeline i_fragmentPipeline (
        .clk, .rstN, .fragValid, .fragIndex, .fragDepth, .fragColor, .fragTexel,
        .depthFunc, .depthTestEnable, .alphaFunc, .alphaRef, .texEnvMode, .texEnvColor,
        .blendSrc, .blendDst, .colorReadIndex, .depthReadIndex, .colorIn, .depthIn,
        .colorWriteIndex, .colorOut, .colorWriteEnable,
        .depthWriteIndex, .depthOut, .depthWriteEnable
    );

    initial
    begin
        forever #5 clk = ~clk;
    end

    // Synchronous memories, one clock of read latency
    always @(posedge clk)
    begin
        colorIn <= colorMem[colorReadIndex];
        depthIn <= depthMem[depthReadIndex];
        if (colorWriteEnable)
            colorMem[colorWriteIndex] <= colorOut;
        if (depthWriteEnable)
            depthMem[depthWriteIndex] <= depthOut;
    end

    //////////////////////////////////////////////////
    // Checking
    //////////////////////////////////////////////////
    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic checkValue(
        input string       name,
        input logic [31:0] expected,
        input logic [31:0] actual
    );
        if (actual !== expected)
            abortRun($sformatf("** Error %s: expected %0h, actual %0h", name, expected, actual));
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk)
    begin : compare
        expectT         entry;
        fragPkg::colorT srcRef;
        logic           colorWeRef;
        logic           depthWeRef;
        if (pending.size() != 0 && pending[0].due == cycleCount)
        begin
            entry = pending.pop_front();
            srcRef = texEnvRef(texEnvMode, entry.triColor, entry.texel, texEnvColor);
            colorWeRef = cmpRef(alphaFunc, 16'(srcRef[3:0]), 16'(alphaRef))
                         && (cmpRef(depthFunc, entry.depth, entry.dstDepth) || !depthTestEnable);
            depthWeRef = colorWeRef && depthTestEnable;
            checkValue({testName, " colorWriteEnable"}, 32'(colorWeRef), 32'(colorWriteEnable));
            checkValue({testName, " depthWriteEnable"}, 32'(depthWeRef), 32'(depthWriteEnable));
            checkValue({testName, " colorWriteIndex"}, 32'(entry.index), 32'(colorWriteIndex));
            checkValue({testName, " depthWriteIndex"}, 32'(entry.index), 32'(depthWriteIndex));
            checkValue({testName, " depthOut"}, 32'(entry.depth), 32'(depthOut));
            checkValue({testName, " colorOut"},
                       32'(blendRef(srcRef, entry.dstColor, blendSrc, blendDst)), 32'(colorOut));
        end
        else if (colorWriteEnable !== 1'b0 || depthWriteEnable !== 1'b0)
            abortRun("A write enable is high in a cycle with no fragment due");

        // Both memories are addressed one edge after acceptance
        foreach (pending[i])
        begin
            if (pending[i].due == cycleCount + writeDelay - readDelay)
            begin
                checkValue({testName, " colorReadIndex"},
                           32'(pending[i].index), 32'(colorReadIndex));
                checkValue({testName, " depthReadIndex"},
                           32'(pending[i].index), 32'(depthReadIndex));
            end
        end

        // Driven at the last rising edge, accepted at the next one
        if (rstN && fragValid)
            pending.push_back('{index: fragIndex, depth: fragDepth, triColor: fragColor,
                                texel: fragTexel, dstColor: colorInit[fragIndex],
                                dstDepth: depthInit[fragIndex], due: cycleCount + writeDelay});
        cycleCount++;
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////
    // Back-to-back fragments to fresh indices, then wait for the drain
    task automatic runGroup(input int count, input bit matchDepth);
        fragPkg::indexT idx;
        bit             coin;
        for (int i = 0; i < count; i++)
        begin
            @(posedge clk);
            idx = fragPkg::indexT'(fragCount * 37 + 5);
            coin = 1'($random(seed));
            fragCount++;
            fragValid <= 1'b1;
            fragIndex <= idx;
            fragColor <= 16'($random(seed));
            fragTexel <= 16'($random(seed));
            // Equal depths now and then, so the equal functions see both outcomes
            if (matchDepth && coin)
                fragDepth <= depthInit[idx];
            else
                fragDepth <= 16'($random(seed));
        end
        @(posedge clk);
        fragValid <= 1'b0;
        while (pending.size() != 0)
            @(posedge clk);
    endtask

    initial
    begin
        for (int i = 0; i < memDepth; i++)
        begin
            colorMem[i]  = 16'($random(seed));
            depthMem[i]  = 16'($random(seed));
            colorInit[i] = colorMem[i];
            depthInit[i] = depthMem[i];
        end
        repeat (4) @(posedge clk);
        rstN <= 1'b1;
        repeat (6) @(posedge clk);

        testName = "texEnv";
        for (int m = 0; m < 6; m++)
        begin
            texEnvMode  <= fragPkg::texEnvE'(3'(m));
            texEnvColor <= 16'($random(seed));
            runGroup(fragsPerGroup, 1'b0);
        end

        testName = "depthTest";
        texEnvMode <= fragPkg::texModulate;
        for (int f = 0; f < 8; f++)
        begin
            for (int en = 0; en < 2; en++)
            begin
                depthFunc       <= fragPkg::cmpFuncE'(3'(f));
                depthTestEnable <= (en == 0);
                runGroup(fragsPerGroup, 1'b1);
            end
        end

        testName = "alphaTest";
        depthFunc       <= fragPkg::cmpAlways;
        depthTestEnable <= 1'b1;
        texEnvMode      <= fragPkg::texReplace;
        for (int f = 0; f < 8; f++)
        begin
            alphaFunc <= fragPkg::cmpFuncE'(3'(f));
            alphaRef  <= 4'($random(seed));
            runGroup(fragsPerGroup, 1'b0);
        end

        testName = "blend";
        alphaFunc <= fragPkg::cmpAlways;
        for (int g = 0; g < 24; g++)
        begin
            texEnvMode <= fragPkg::texEnvE'(3'($unsigned($random(seed)) % 6));
            blendSrc   <= (g == 0) ? fragPkg::blendSrcAlphaSaturate
                          : fragPkg::blendFactorE'(4'($unsigned($random(seed)) % 11));
            blendDst   <= (g == 1) ? fragPkg::blendSrcAlphaSaturate
                          : fragPkg::blendFactorE'(4'($unsigned($random(seed)) % 11));
            runGroup(fragsPerGroup, 1'b0);
        end

        // A few idle cycles catch a stray write enable after the last fragment
        repeat (4) @(posedge clk);
        $display("TEST OK");
        $finish;
    end

    // Watchdog
    initial
    begin
        #(runCycles * 10);
        $display("Watchdog expired before all fragments were written back");
        $display("TEST FAILED");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+.
fragPkg.sv
fragStageIf.sv
fragDecode.sv
fragExecute.sv
fragResult.sv
fragmentPipeline.sv
tbFragmentPipeline.sv

// File: Makefile
# Verilator build and run of the fragment pipeline testbench

TOP := tbFragmentPipeline

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f tb.f --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

lint:
	verilator --lint-only --timing -f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir
